/* include/soc_defs.svh */
// Peripheral SoC address map
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// ----------------------------------------------------------
// Device regions
// ----------------------------------------------------------

// Word RAM with a power-of-two size
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_RAM_BYTES 1024

// GPIO register block
`define SOC_GPIO_BASE 32'h8002_0000
`define SOC_GPIO_BYTES 32

// External accelerator behind the APB port
`define SOC_ACCEL_BASE 32'h8005_0000
`define SOC_ACCEL_BYTES 65536

// ----------------------------------------------------------
// Device sizes and register offsets
// ----------------------------------------------------------

`define SOC_GPIO_WIDTH 8

`define SOC_GPIO_IN_OFS 5'h00
`define SOC_GPIO_OE_OFS 5'h04
`define SOC_GPIO_OUT_OFS 5'h08

`define SOC_APB_ADDR_BITS 12

`endif

/* rtl/soc_pkg.sv */
// Peripheral SoC shared types
`include "soc_defs.svh"

package soc_pkg;

  // System bus vectors
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] strobe_t;

  // One bit per GPIO pin
  typedef logic [`SOC_GPIO_WIDTH-1:0] gpio_t;

  // Accelerator register address
  typedef logic [`SOC_APB_ADDR_BITS-1:0] apb_addr_t;

  // APB bridge FSM
  typedef enum logic [1:0] {
    IDLE,
    SEL,
    ENABLE
  } apb_state_t;

  // Device picked by the address decoder
  typedef enum logic [1:0] {
    RAM,
    GPIO,
    ACCEL,
    NONE
  } dev_sel_t;

endpackage

/* rtl/device_bus_if.sv */
// System bus device link
interface device_bus_if;

  // Request side, driven by the bus
  soc_pkg::addr_t address;
  soc_pkg::word_t write_data;
  soc_pkg::strobe_t write_strobe;
  logic read_request;
  logic write_request;

  // Response side, driven by the device
  soc_pkg::word_t read_data;
  logic read_response;
  logic write_response;

  modport manager (
    output address, write_data, write_strobe, read_request, write_request,
    input  read_data, read_response, write_response
  );

  modport device (
    input  address, write_data, write_strobe, read_request, write_request,
    output read_data, read_response, write_response
  );

endinterface

/* rtl/system_bus.sv */
// System bus decoder and response mux
`include "soc_defs.svh"

module system_bus (
  input  logic              clock_i,
  input  logic              reset_i,
  input  soc_pkg::addr_t    addr_i,
  input  soc_pkg::word_t    write_data_i,
  input  soc_pkg::strobe_t  write_strobe_i,
  input  logic              read_request_i,
  input  logic              write_request_i,
  output soc_pkg::word_t    read_data_o,
  output logic              read_response_o,
  output logic              write_response_o,
  device_bus_if.manager     ram_bus,
  device_bus_if.manager     gpio_bus,
  device_bus_if.manager     accel_bus
);

  localparam int ram_lsb = $clog2(`SOC_RAM_BYTES);
  localparam int gpio_lsb = $clog2(`SOC_GPIO_BYTES);
  localparam int accel_lsb = $clog2(`SOC_ACCEL_BYTES);
  localparam soc_pkg::addr_t ram_base = `SOC_RAM_BASE;
  localparam soc_pkg::addr_t gpio_base = `SOC_GPIO_BASE;
  localparam soc_pkg::addr_t accel_base = `SOC_ACCEL_BASE;

  soc_pkg::dev_sel_t sel;
  soc_pkg::dev_sel_t sel_q;
  logic none_read_q;
  logic none_write_q;

  // ----------------------------------------------------------
  // Address decode and request routing
  // ----------------------------------------------------------

  always_comb begin
    if (addr_i[31:ram_lsb] == ram_base[31:ram_lsb]) begin
      sel = soc_pkg::RAM;
    end else if (addr_i[31:gpio_lsb] == gpio_base[31:gpio_lsb]) begin
      sel = soc_pkg::GPIO;
    end else if (addr_i[31:accel_lsb] == accel_base[31:accel_lsb]) begin
      sel = soc_pkg::ACCEL;
    end else begin
      sel = soc_pkg::NONE;
    end
  end

  assign ram_bus.address        = addr_i;
  assign ram_bus.write_data     = write_data_i;
  assign ram_bus.write_strobe   = write_strobe_i;
  assign ram_bus.read_request   = read_request_i && (sel == soc_pkg::RAM);
  assign ram_bus.write_request  = write_request_i && (sel == soc_pkg::RAM);

  assign gpio_bus.address       = addr_i;
  assign gpio_bus.write_data    = write_data_i;
  assign gpio_bus.write_strobe  = write_strobe_i;
  assign gpio_bus.read_request  = read_request_i && (sel == soc_pkg::GPIO);
  assign gpio_bus.write_request = write_request_i && (sel == soc_pkg::GPIO);

  assign accel_bus.address       = addr_i;
  assign accel_bus.write_data    = write_data_i;
  assign accel_bus.write_strobe  = write_strobe_i;
  assign accel_bus.read_request  = read_request_i && (sel == soc_pkg::ACCEL);
  assign accel_bus.write_request = write_request_i && (sel == soc_pkg::ACCEL);

  // ----------------------------------------------------------
  // Response path
  // ----------------------------------------------------------

  // Selection held until the next request
  // Unmapped requests answered here
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      sel_q        <= soc_pkg::NONE;
      none_read_q  <= 1'b0;
      none_write_q <= 1'b0;
    end else begin
      if (read_request_i || write_request_i) begin
        sel_q <= sel;
      end
      none_read_q  <= read_request_i && (sel == soc_pkg::NONE);
      none_write_q <= write_request_i && (sel == soc_pkg::NONE);
    end
  end

  always_comb begin
    case (sel_q)
      soc_pkg::RAM: begin
        read_data_o      = ram_bus.read_data;
        read_response_o  = ram_bus.read_response;
        write_response_o = ram_bus.write_response;
      end
      soc_pkg::GPIO: begin
        read_data_o      = gpio_bus.read_data;
        read_response_o  = gpio_bus.read_response;
        write_response_o = gpio_bus.write_response;
      end
      soc_pkg::ACCEL: begin
        read_data_o      = accel_bus.read_data;
        read_response_o  = accel_bus.read_response;
        write_response_o = accel_bus.write_response;
      end
      default: begin
        read_data_o      = '0;
        read_response_o  = none_read_q;
        write_response_o = none_write_q;
      end
    endcase
  end

endmodule

/* rtl/ram_device.sv */
// Byte-strobed word RAM
`include "soc_defs.svh"

module ram_device (
  input  logic          clock_i,
  input  logic          reset_i,
  device_bus_if.device  bus
);

  localparam int words = `SOC_RAM_BYTES / 4;
  localparam int index_bits = $clog2(words);

  soc_pkg::word_t mem [words];
  soc_pkg::word_t read_data_q;
  logic [index_bits-1:0] index;

  // Word index within the region
  assign index = bus.address[index_bits+1:2];

  // Storage and read port
  always_ff @(posedge clock_i) begin
    for (int i = 0; i < 4; i++) begin
      if (bus.write_request && bus.write_strobe[i]) begin
        mem[index][8*i +: 8] <= bus.write_data[8*i +: 8];
      end
    end
    if (bus.read_request) begin
      read_data_q <= mem[index];
    end
  end

  // Response one cycle after the request
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      bus.read_response  <= 1'b0;
      bus.write_response <= 1'b0;
    end else begin
      bus.read_response  <= bus.read_request;
      bus.write_response <= bus.write_request;
    end
  end

  assign bus.read_data = read_data_q;

endmodule

/* rtl/gpio_device.sv */
// GPIO register block
`include "soc_defs.svh"

module gpio_device (
  input  logic            clock_i,
  input  logic            reset_i,
  device_bus_if.device    bus,
  input  soc_pkg::gpio_t  gpio_input_i,
  output soc_pkg::gpio_t  gpio_oe_o,
  output soc_pkg::gpio_t  gpio_output_o
);

  soc_pkg::gpio_t input_meta;
  soc_pkg::gpio_t input_sync;
  soc_pkg::word_t read_data_q;
  logic [4:0] offset;

  assign offset = bus.address[4:0];

  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      input_meta         <= '0;
      input_sync         <= '0;
      gpio_oe_o          <= '0;
      gpio_output_o      <= '0;
      bus.read_response  <= 1'b0;
      bus.write_response <= 1'b0;
    end else begin
      // Two-flop synchronizer on the pins
      input_meta <= gpio_input_i;
      input_sync <= input_meta;
      // Only byte 0 carries pin data
      if (bus.write_request && bus.write_strobe[0]) begin
        if (offset == `SOC_GPIO_OE_OFS) begin
          gpio_oe_o <= bus.write_data[`SOC_GPIO_WIDTH-1:0];
        end else if (offset == `SOC_GPIO_OUT_OFS) begin
          gpio_output_o <= bus.write_data[`SOC_GPIO_WIDTH-1:0];
        end
      end
      bus.read_response  <= bus.read_request;
      bus.write_response <= bus.write_request;
    end
  end

  // Read word captured with the request
  always_ff @(posedge clock_i) begin
    if (bus.read_request) begin
      case (offset)
        `SOC_GPIO_IN_OFS:  read_data_q <= soc_pkg::word_t'(input_sync);
        `SOC_GPIO_OE_OFS:  read_data_q <= soc_pkg::word_t'(gpio_oe_o);
        `SOC_GPIO_OUT_OFS: read_data_q <= soc_pkg::word_t'(gpio_output_o);
        default:           read_data_q <= '0;
      endcase
    end
  end

  assign bus.read_data = read_data_q;

endmodule

/* rtl/accel_apb_port.sv */
// Accelerator APB bridge
`include "soc_defs.svh"

module accel_apb_port (
  input  logic                clock_i,
  input  logic                reset_i,
  device_bus_if.device        bus,
  output soc_pkg::apb_addr_t  paddr_o,
  output logic                psel_o,
  output logic                penable_o,
  output logic                pwrite_o,
  output soc_pkg::word_t      pwdata_o,
  input  soc_pkg::word_t      prdata_i,
  input  logic                pready_i,
  input  logic                accel_irq_i,
  input  logic                irq_response_i,
  output logic                irq_o
);

  soc_pkg::apb_state_t state;
  logic request;
  logic done;
  logic irq_q;

  assign request = bus.read_request || bus.write_request;

  // ----------------------------------------------------------
  // APB transfer sequencing
  // ----------------------------------------------------------

  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      state <= soc_pkg::IDLE;
    end else begin
      case (state)
        soc_pkg::IDLE:   if (request) state <= soc_pkg::SEL;
        soc_pkg::SEL:    state <= soc_pkg::ENABLE;
        soc_pkg::ENABLE: if (pready_i) state <= soc_pkg::IDLE;
        default:         state <= soc_pkg::IDLE;
      endcase
    end
  end

  // Transfer fields held for the whole APB access
  always_ff @(posedge clock_i) begin
    if (request && state == soc_pkg::IDLE) begin
      paddr_o  <= bus.address[`SOC_APB_ADDR_BITS-1:0];
      pwdata_o <= bus.write_data;
      pwrite_o <= bus.write_request;
    end
  end

  assign psel_o    = (state != soc_pkg::IDLE);
  assign penable_o = (state == soc_pkg::ENABLE);

  // Completing ENABLE cycle
  assign done = penable_o && pready_i;

  assign bus.read_response  = done && !pwrite_o;
  assign bus.write_response = done && pwrite_o;
  assign bus.read_data      = prdata_i;

  // ----------------------------------------------------------
  // Interrupt pending
  // ----------------------------------------------------------

  // New edge wins over a clear in the same cycle
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      irq_q <= 1'b0;
      irq_o <= 1'b0;
    end else begin
      irq_q <= accel_irq_i;
      if (accel_irq_i && !irq_q) begin
        irq_o <= 1'b1;
      end else if (irq_response_i) begin
        irq_o <= 1'b0;
      end
    end
  end

endmodule

/* rtl/periph_soc.sv */
// Peripheral SoC top level
module periph_soc (
  input  logic                clock,
  input  logic                reset,
  // Manager request and response
  input  soc_pkg::addr_t      addr_i,
  input  soc_pkg::word_t      write_data_i,
  input  soc_pkg::strobe_t    write_strobe_i,
  input  logic                read_request_i,
  input  logic                write_request_i,
  output soc_pkg::word_t      read_data_o,
  output logic                read_response_o,
  output logic                write_response_o,
  // GPIO pins
  input  soc_pkg::gpio_t      gpio_input_i,
  output soc_pkg::gpio_t      gpio_oe_o,
  output soc_pkg::gpio_t      gpio_output_o,
  // Accelerator APB and interrupt
  output soc_pkg::apb_addr_t  paddr_o,
  output logic                psel_o,
  output logic                penable_o,
  output logic                pwrite_o,
  output soc_pkg::word_t      pwdata_o,
  input  soc_pkg::word_t      prdata_i,
  input  logic                pready_i,
  input  logic                accel_irq_i,
  input  logic                irq_response_i,
  output logic                irq_o
);

  device_bus_if ram_bus ();
  device_bus_if gpio_bus ();
  device_bus_if accel_bus ();

  system_bus bus0 (
    .clock_i          (clock),
    .reset_i          (reset),
    .addr_i           (addr_i),
    .write_data_i     (write_data_i),
    .write_strobe_i   (write_strobe_i),
    .read_request_i   (read_request_i),
    .write_request_i  (write_request_i),
    .read_data_o      (read_data_o),
    .read_response_o  (read_response_o),
    .write_response_o (write_response_o),
    .ram_bus          (ram_bus.manager),
    .gpio_bus         (gpio_bus.manager),
    .accel_bus        (accel_bus.manager)
  );

  ram_device ram0 (
    .clock_i (clock),
    .reset_i (reset),
    .bus     (ram_bus.device)
  );

  gpio_device gpio0 (
    .clock_i       (clock),
    .reset_i       (reset),
    .bus           (gpio_bus.device),
    .gpio_input_i  (gpio_input_i),
    .gpio_oe_o     (gpio_oe_o),
    .gpio_output_o (gpio_output_o)
  );

  accel_apb_port accel0 (
    .clock_i        (clock),
    .reset_i        (reset),
    .bus            (accel_bus.device),
    .paddr_o        (paddr_o),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .pwrite_o       (pwrite_o),
    .pwdata_o       (pwdata_o),
    .prdata_i       (prdata_i),
    .pready_i       (pready_i),
    .accel_irq_i    (accel_irq_i),
    .irq_response_i (irq_response_i),
    .irq_o          (irq_o)
  );

endmodule

/* tests/periph_soc_sva.sv */
// Bus and APB protocol assertions
module periph_soc_sva (
  input  logic  clock_i,
  input  logic  reset_i,
  input  logic  read_request_i,
  input  logic  write_request_i,
  input  logic  read_response_i,
  input  logic  write_response_i,
  input  logic  psel_i,
  input  logic  penable_i,
  input  logic  pready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic pending;
  int failures;

  initial failures = 0;

  // One request in flight at a time
  always_ff @(posedge clock_i or posedge reset_i) begin
    if (reset_i) begin
      pending <= 1'b0;
    end else if (read_request_i || write_request_i) begin
      pending <= 1'b1;
    end else if (read_response_i || write_response_i) begin
      pending <= 1'b0;
    end
  end

  response_has_request: assert property (@(posedge clock_i) disable iff (reset_i)
    (read_response_i || write_response_i) |-> pending)
    else begin
      failures++;
      $error("Bus response with no outstanding request");
    end

  // Setup phase comes first
  enable_after_setup: assert property (@(posedge clock_i) disable iff (reset_i)
    $rose(penable_i) |-> $past(psel_i && !penable_i))
    else begin
      failures++;
      $error("penable rose without a setup cycle");
    end

  select_held: assert property (@(posedge clock_i) disable iff (reset_i)
    (psel_i && !(penable_i && pready_i)) |=> psel_i)
    else begin
      failures++;
      $error("psel dropped before pready");
    end

endmodule

bind periph_soc periph_soc_sva sva0 (
  .clock_i          (clock),
  .reset_i          (reset),
  .read_request_i   (read_request_i),
  .write_request_i  (write_request_i),
  .read_response_i  (read_response_o),
  .write_response_i (write_response_o),
  .psel_i           (psel_o),
  .penable_i        (penable_o),
  .pready_i         (pready_i)
);

/* tests/bus_checker.sv */
// Bus response checker
`include "soc_defs.svh"

module bus_checker (
  input  logic                clock_i,
  input  logic                reset_i,
  input  soc_pkg::addr_t      addr_i,
  input  soc_pkg::word_t      write_data_i,
  input  soc_pkg::strobe_t    write_strobe_i,
  input  logic                read_request_i,
  input  logic                write_request_i,
  input  soc_pkg::word_t      read_data_i,
  input  logic                read_response_i,
  input  logic                write_response_i,
  input  soc_pkg::gpio_t      gpio_input_i,
  input  soc_pkg::gpio_t      gpio_oe_i,
  input  soc_pkg::gpio_t      gpio_output_i,
  input  soc_pkg::apb_addr_t  paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  soc_pkg::word_t      pwdata_i,
  input  logic                pready_i,
  input  logic                accel_irq_i,
  input  logic                irq_response_i,
  input  logic                irq_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int apb_words = 2 ** (`SOC_APB_ADDR_BITS - 2);

  int errors;
  int test_start;
  int tests_passed;
  int tests_failed;
  int age;
  logic [7:0] ram_model [`SOC_RAM_BYTES];
  soc_pkg::word_t apb_model [apb_words];
  soc_pkg::gpio_t oe_model;
  soc_pkg::gpio_t out_model;
  logic irq_model;
  logic irq_prev;
  logic outstanding;
  logic exp_read;
  soc_pkg::dev_sel_t exp_dev;
  soc_pkg::word_t exp_data;
  soc_pkg::apb_addr_t exp_paddr;
  soc_pkg::word_t exp_wdata;

  // Accelerator register contents after reset
  function automatic soc_pkg::word_t apb_fill(input int unsigned i);
    soc_pkg::word_t a;
    a = soc_pkg::word_t'(i) << 2;
    return (a * 32'h9E37_79B9) ^ 32'hC0DE_0000;
  endfunction

  function automatic soc_pkg::dev_sel_t decode(input soc_pkg::addr_t a);
    if (a >= `SOC_RAM_BASE && a < `SOC_RAM_BASE + `SOC_RAM_BYTES) return soc_pkg::RAM;
    if (a >= `SOC_GPIO_BASE && a < `SOC_GPIO_BASE + `SOC_GPIO_BYTES) return soc_pkg::GPIO;
    if (a >= `SOC_ACCEL_BASE && a < `SOC_ACCEL_BASE + `SOC_ACCEL_BYTES) return soc_pkg::ACCEL;
    return soc_pkg::NONE;
  endfunction

  task automatic check_value(input string name, input soc_pkg::word_t got,
                             input soc_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fail_note(input string what);
    errors++;
    $display("At %0t: %s", $time, what);
  endtask

  initial begin
    errors = 0;
    test_start = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < apb_words; i++) begin
      apb_model[i] = apb_fill(i);
    end
  end

  // ----------------------------------------------------------
  // Per-cycle comparison
  // ----------------------------------------------------------

  always @(posedge clock_i) begin
    int unsigned ofs;
    if (reset_i) begin
      oe_model = '0;
      out_model = '0;
      irq_model = 1'b0;
      irq_prev = 1'b0;
      outstanding = 1'b0;
    end else begin
      check_value("gpio_oe_o", soc_pkg::word_t'(gpio_oe_i), soc_pkg::word_t'(oe_model));
      check_value("gpio_output_o", soc_pkg::word_t'(gpio_output_i),
                  soc_pkg::word_t'(out_model));
      check_value("irq_o", soc_pkg::word_t'(irq_i), soc_pkg::word_t'(irq_model));
      // Edge beats clear
      if (accel_irq_i && !irq_prev) begin
        irq_model = 1'b1;
      end else if (irq_response_i) begin
        irq_model = 1'b0;
      end
      irq_prev = accel_irq_i;

      if (psel_i && penable_i && pready_i) begin
        check_value("paddr_o", soc_pkg::word_t'(paddr_i), soc_pkg::word_t'(exp_paddr));
        check_value("pwrite_o", soc_pkg::word_t'(pwrite_i), soc_pkg::word_t'(!exp_read));
        if (!exp_read) begin
          check_value("pwdata_o", pwdata_i, exp_wdata);
          apb_model[exp_paddr[`SOC_APB_ADDR_BITS-1:2]] = exp_wdata;
        end
      end

      if (read_response_i || write_response_i) begin
        if (!outstanding) begin
          fail_note("bus response without an outstanding request");
        end else begin
          check_value("read_response_o", soc_pkg::word_t'(read_response_i),
                      soc_pkg::word_t'(exp_read));
          check_value("write_response_o", soc_pkg::word_t'(write_response_i),
                      soc_pkg::word_t'(!exp_read));
          if (exp_dev == soc_pkg::ACCEL && age == 0) begin
            fail_note("accelerator response sooner than two cycles after the request");
          end
          if (exp_dev == soc_pkg::ACCEL && !(psel_i && penable_i && pready_i)) begin
            fail_note("accelerator response outside the completing APB cycle");
          end
          if (exp_dev == soc_pkg::ACCEL) begin
            exp_data = apb_model[exp_paddr[`SOC_APB_ADDR_BITS-1:2]];
          end
          if (read_response_i) begin
            check_value("read_data_o", read_data_i, exp_data);
          end
          outstanding = 1'b0;
        end
      end else if (outstanding) begin
        if (exp_dev != soc_pkg::ACCEL) begin
          fail_note("no bus response one cycle after the request");
          outstanding = 1'b0;
        end
        age++;
      end

      if (read_request_i || write_request_i) begin
        outstanding = 1'b1;
        age = 0;
        exp_read = read_request_i;
        exp_dev = decode(addr_i);
        exp_paddr = addr_i[`SOC_APB_ADDR_BITS-1:0];
        exp_wdata = write_data_i;
        exp_data = '0;
        case (exp_dev)
          soc_pkg::RAM: begin
            ofs = (addr_i % `SOC_RAM_BYTES) & ~32'd3;
            for (int b = 0; b < 4; b++) begin
              if (write_request_i && write_strobe_i[b]) begin
                ram_model[ofs + b] = write_data_i[8*b +: 8];
              end
              exp_data[8*b +: 8] = ram_model[ofs + b];
            end
          end
          soc_pkg::GPIO: begin
            if (write_request_i && write_strobe_i[0]) begin
              if (addr_i[4:0] == `SOC_GPIO_OE_OFS) oe_model = write_data_i[`SOC_GPIO_WIDTH-1:0];
              if (addr_i[4:0] == `SOC_GPIO_OUT_OFS) out_model = write_data_i[`SOC_GPIO_WIDTH-1:0];
            end
            case (addr_i[4:0])
              `SOC_GPIO_IN_OFS:  exp_data = soc_pkg::word_t'(gpio_input_i);
              `SOC_GPIO_OE_OFS:  exp_data = soc_pkg::word_t'(oe_model);
              `SOC_GPIO_OUT_OFS: exp_data = soc_pkg::word_t'(out_model);
              default:           exp_data = '0;
            endcase
          end
          default: exp_data = '0;
        endcase
      end
    end
  end

  // ----------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------

  task automatic check_reset_values();
    check_value("read_response_o", soc_pkg::word_t'(read_response_i), '0);
    check_value("write_response_o", soc_pkg::word_t'(write_response_i), '0);
    check_value("psel_o", soc_pkg::word_t'(psel_i), '0);
    check_value("penable_o", soc_pkg::word_t'(penable_i), '0);
    check_value("irq_o", soc_pkg::word_t'(irq_i), '0);
    check_value("gpio_oe_o", soc_pkg::word_t'(gpio_oe_i), '0);
    check_value("gpio_output_o", soc_pkg::word_t'(gpio_output_i), '0);
  endtask

  task automatic end_test(input string name);
    if (errors == test_start) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic report_counts();
    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
  endtask

endmodule

/* tests/periph_soc_tb.sv */
// Peripheral SoC testbench
`include "soc_defs.svh"

module periph_soc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int apb_words = 2 ** (`SOC_APB_ADDR_BITS - 2);

  logic clock;
  logic reset;
  soc_pkg::addr_t addr_i;
  soc_pkg::word_t write_data_i;
  soc_pkg::strobe_t write_strobe_i;
  logic read_request_i;
  logic write_request_i;
  soc_pkg::word_t read_data_o;
  logic read_response_o;
  logic write_response_o;
  soc_pkg::gpio_t gpio_input_i;
  soc_pkg::gpio_t gpio_oe_o;
  soc_pkg::gpio_t gpio_output_o;
  soc_pkg::apb_addr_t paddr_o;
  logic psel_o;
  logic penable_o;
  logic pwrite_o;
  soc_pkg::word_t pwdata_o;
  soc_pkg::word_t prdata_i;
  logic pready_i;
  logic accel_irq_i;
  logic irq_response_i;
  logic irq_o;

  logic [31:0] stim_lfsr;
  logic [31:0] apb_lfsr;
  soc_pkg::word_t apb_mem [apb_words];
  logic timed_out;

  periph_soc dut0 (.*);

  bus_checker chk0 (
    .clock_i (clock), .reset_i (reset), .addr_i (addr_i), .write_data_i (write_data_i),
    .write_strobe_i (write_strobe_i), .read_request_i (read_request_i),
    .write_request_i (write_request_i), .read_data_i (read_data_o),
    .read_response_i (read_response_o), .write_response_i (write_response_o),
    .gpio_input_i (gpio_input_i), .gpio_oe_i (gpio_oe_o), .gpio_output_i (gpio_output_o),
    .paddr_i (paddr_o), .psel_i (psel_o), .penable_i (penable_o), .pwrite_i (pwrite_o),
    .pwdata_i (pwdata_o), .pready_i (pready_i), .accel_irq_i (accel_irq_i),
    .irq_response_i (irq_response_i), .irq_i (irq_o)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // APB responder with random wait states
  always @(posedge clock) begin
    if (psel_o && penable_o && pready_i && pwrite_o) begin
      apb_mem[paddr_o[`SOC_APB_ADDR_BITS-1:2]] = pwdata_o;
    end
    #1;
    apb_lfsr = lfsr_step(apb_lfsr);
    apb_lfsr = lfsr_step(apb_lfsr);
    pready_i = psel_o && (apb_lfsr[1:0] != 2'b00);
    prdata_i = psel_o ? apb_mem[paddr_o[`SOC_APB_ADDR_BITS-1:2]] : '0;
  end

  task automatic bus_access(input logic is_write, input soc_pkg::addr_t a,
                            input soc_pkg::word_t d, input soc_pkg::strobe_t s);
    int waited;
    if (timed_out) return;
    @(posedge clock);
    #1;
    addr_i = a;
    write_data_i = d;
    write_strobe_i = s;
    write_request_i = is_write;
    read_request_i = !is_write;
    @(posedge clock);
    #1;
    read_request_i = 1'b0;
    write_request_i = 1'b0;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!(read_response_o || write_response_o) && waited < 64);
    if (!(read_response_o || write_response_o)) begin
      $display("Timeout: no bus response for address %h", a);
      timed_out = 1'b1;
    end
    // Checker compares the response on this edge
    @(posedge clock);
    #1;
  endtask

  task automatic irq_cycle(input logic level, input logic clear);
    @(posedge clock);
    #1;
    accel_irq_i = level;
    irq_response_i = clear;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    reset = 1'b1;
    addr_i = '0;
    write_data_i = '0;
    write_strobe_i = '0;
    read_request_i = 1'b0;
    write_request_i = 1'b0;
    gpio_input_i = '0;
    prdata_i = '0;
    pready_i = 1'b0;
    accel_irq_i = 1'b0;
    irq_response_i = 1'b0;
    timed_out = 1'b0;
    stim_lfsr = 32'h702;
    apb_lfsr = 32'h702;
    for (int i = 0; i < apb_words; i++) begin
      apb_mem[i] = chk0.apb_fill(i);
    end
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    chk0.check_reset_values();
    chk0.end_test("reset");

    // Full words first so later reads see no unknown bytes
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b1, `SOC_RAM_BASE + 32'(i * 4), take_bits(32), 4'hf);
    end
    for (int i = 0; i < 32; i++) begin
      r = take_bits(4);
      d = take_bits(32);
      bus_access(1'b1, `SOC_RAM_BASE + (r << 2), d, soc_pkg::strobe_t'(take_bits(4)));
    end
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, `SOC_RAM_BASE + 32'(i * 4), '0, '0);
    end
    chk0.end_test("ram");

    for (int i = 0; i < 8; i++) begin
      bus_access(1'b1, `SOC_GPIO_BASE + `SOC_GPIO_OE_OFS, take_bits(32),
                 soc_pkg::strobe_t'(take_bits(4)));
      bus_access(1'b1, `SOC_GPIO_BASE + `SOC_GPIO_OUT_OFS, take_bits(32), 4'hf);
      r = take_bits(`SOC_GPIO_WIDTH);
      gpio_input_i = r[`SOC_GPIO_WIDTH-1:0];
      repeat (3) @(posedge clock);
      bus_access(1'b0, `SOC_GPIO_BASE + `SOC_GPIO_IN_OFS, '0, '0);
      bus_access(1'b0, `SOC_GPIO_BASE + `SOC_GPIO_OE_OFS, '0, '0);
      bus_access(1'b0, `SOC_GPIO_BASE + `SOC_GPIO_OUT_OFS, '0, '0);
      bus_access(1'b0, `SOC_GPIO_BASE + 32'h0c, '0, '0);
    end
    chk0.end_test("gpio");

    for (int i = 0; i < 24; i++) begin
      r = take_bits(14);
      d = take_bits(32);
      bus_access(take_bits(1) != 0, `SOC_ACCEL_BASE + (r << 2), d, 4'hf);
    end
    chk0.end_test("accelerator");

    for (int i = 0; i < 4; i++) begin
      r = take_bits(12);
      bus_access(1'b1, 32'h4000_0000 + r, take_bits(32), 4'hf);
      bus_access(1'b0, 32'h4000_0000 + r, '0, '0);
    end
    chk0.end_test("unmapped");

    // Rising edges, level held, clear, and an edge during a clear
    irq_cycle(1'b1, 1'b0);
    irq_cycle(1'b1, 1'b0);
    irq_cycle(1'b1, 1'b1);
    irq_cycle(1'b1, 1'b0);
    irq_cycle(1'b0, 1'b0);
    irq_cycle(1'b1, 1'b1);
    irq_cycle(1'b1, 1'b0);
    irq_cycle(1'b0, 1'b1);
    repeat (2) irq_cycle(1'b0, 1'b0);
    chk0.end_test("interrupt");

    chk0.report_counts();
    if (!timed_out && chk0.errors == 0 && dut0.sva0.failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
rtl/soc_pkg.sv
rtl/device_bus_if.sv
rtl/system_bus.sv
rtl/ram_device.sv
rtl/gpio_device.sv
rtl/accel_apb_port.sv
rtl/periph_soc.sv
tests/periph_soc_sva.sv
tests/bus_checker.sv
tests/periph_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := periph_soc_tb
FILELIST  := verilog.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/soc_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
